/* hw/snes_bus_pkg.sv */
`default_nettype none

package snes_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // snes side widths and sampling depth
  ////////////////////////////////////////////////////////////////////////////

  // full snes cpu address
  parameter int SNES_ADDR_W = 24;

  // stages in the input sampling history
  parameter int SYNC_DEPTH = 7;

  // filtered bus levels, all active low except the clock
  typedef struct packed {
    logic [SNES_ADDR_W-1:0] addr;
    logic                   read;
    logic                   write;
    logic                   romsel;
    logic                   cpu_clk;
  } snes_bus_t;

endpackage

`default_nettype wire

/* hw/rom_mem_pkg.sv */
`default_nettype none

package rom_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // psram side
  ////////////////////////////////////////////////////////////////////////////

  // word address, byte address is one bit wider
  parameter int ROM_ADDR_W = 23;

  // one request from a client, rrq/wrq are one-cycle pulses
  typedef struct packed {
    logic                rrq;
    logic                wrq;
    logic                word;    // coprocessor only
    logic [ROM_ADDR_W:0] addr;    // byte address
    logic [15:0]         wdata;
  } mem_req_t;

  typedef struct packed {
    logic        rdy;
    logic [15:0] rdata;
  } mem_rsp_t;

  // arbiter states, address phase then one end cycle per client op
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_GSU_RD_ADDR,
    ST_GSU_RD_END,
    ST_GSU_WR_ADDR,
    ST_GSU_WR_END,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_END
  } arb_state_t;

  // one psram word as a whole or per byte lane
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;   // even byte on the bhe lane
      logic [7:0] lo;   // odd byte on the ble lane
    } b;
  } rom_word_u;

endpackage

`default_nettype wire

/* hw/snes_bus_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync #(
  parameter int unsigned DEAD_TIMEOUT = 96000
) (
  input  logic                               CLK2,
  input  logic                               SNES_reset_strobe,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] addr_in,
  input  logic                               read_in,
  input  logic                               write_in,
  input  logic                               romsel_in,
  input  logic                               cpu_clk_in,
  output snes_bus_pkg::snes_bus_t            bus,
  output logic                               free_slot,
  output logic                               snes_dead
);

  import snes_bus_pkg::*;

  // width of the edge pattern window
  localparam int PW = SYNC_DEPTH - 1;
  localparam logic [PW-1:0] RISE_PAT = PW'(3);
  localparam logic [PW-1:0] FALL_PAT = ~PW'(7);
  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);
  localparam logic [CNT_W-1:0] DEAD_LIMIT = CNT_W'(DEAD_TIMEOUT);

  ////////////////////////////////////////////////////////////////////////////
  // sampling histories
  ////////////////////////////////////////////////////////////////////////////

  logic [SYNC_DEPTH-1:0]  cpu_clk_r;
  logic [SYNC_DEPTH-2:0]  romsel_r;
  logic [2:0]             read_r;
  logic [2:0]             write_r;
  logic [SNES_ADDR_W-1:0] addr_r [SYNC_DEPTH-1];

  logic             cycle_start;
  logic             cycle_end;
  logic             free_strobe;
  logic [CNT_W-1:0] dead_cnt;

  // control histories start idle, strobes high and clock low
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      cpu_clk_r <= '0;
      romsel_r  <= '1;
      read_r    <= '1;
      write_r   <= '1;
    end else begin
      cpu_clk_r <= {cpu_clk_r[SYNC_DEPTH-2:0], cpu_clk_in};
      romsel_r  <= {romsel_r[SYNC_DEPTH-3:0], romsel_in};
      read_r    <= {read_r[1:0], read_in};
      write_r   <= {write_r[1:0], write_in};
    end
  end

  // address settles slowest, keep the deepest history
  always_ff @(posedge CLK2) begin
    addr_r[0] <= addr_in;
    for (int i = 1; i < SYNC_DEPTH - 1; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  // glitch filter, two adjacent samples must agree
  assign bus.addr    = addr_r[SYNC_DEPTH-2] & addr_r[SYNC_DEPTH-3];
  assign bus.romsel  = romsel_r[SYNC_DEPTH-2] & romsel_r[SYNC_DEPTH-3];
  assign bus.read    = read_r[2] & read_r[1];
  assign bus.write   = write_r[2] & write_r[1];
  assign bus.cpu_clk = cpu_clk_r[2] & cpu_clk_r[1];

  ////////////////////////////////////////////////////////////////////////////
  // cycle edges and free slots
  ////////////////////////////////////////////////////////////////////////////

  // rising cpu clock, two clean highs after a clean low run
  assign cycle_start = ((cpu_clk_r[PW:1] & cpu_clk_r[PW-1:0]) == RISE_PAT);
  // falling cpu clock, three lows after a high run
  assign cycle_end   = ((cpu_clk_r[PW:1] | cpu_clk_r[PW-1:0]) == FALL_PAT);

  // no rom hit in this cycle so the bus is ours right away
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & bus.romsel;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////////////////////
  // dead console detect
  ////////////////////////////////////////////////////////////////////////////

  // counts clock-low cycles, saturates past the limit
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else begin
      if (cpu_clk_r[0]) begin
        dead_cnt <= '0;
      end else if (dead_cnt <= DEAD_LIMIT) begin
        dead_cnt <= dead_cnt + 1'b1;
      end
      // any clock high revives the console
      if (cpu_clk_r[0]) begin
        snes_dead <= 1'b0;
      end else if (dead_cnt > DEAD_LIMIT) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rom_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter #(
  parameter int unsigned ROM_CYCLE_LEN = 6
) (
  input  logic                            CLK2,
  input  logic                            SNES_reset_strobe,
  input  logic                            free_slot,
  input  logic                            snes_dead,
  input  rom_mem_pkg::mem_req_t           gsu_req,
  input  rom_mem_pkg::mem_req_t           mcu_req,
  input  logic [15:0]                     rom_dq_in,
  output rom_mem_pkg::mem_rsp_t           gsu_rsp,
  output rom_mem_pkg::mem_rsp_t           mcu_rsp,
  output logic [rom_mem_pkg::ROM_ADDR_W:0] acc_addr,
  output logic                            acc_word,
  output logic                            acc_write,
  output logic                            acc_active,
  output logic [15:0]                     acc_wdata
);

  import rom_mem_pkg::*;

  // client slot index 0 has priority
  localparam int GSU = 0;
  localparam int MCU = 1;
  localparam int DLY_W = $clog2(ROM_CYCLE_LEN + 1);
  localparam logic [DLY_W-1:0] CYCLE_INIT = DLY_W'(ROM_CYCLE_LEN);

  arb_state_t       state;
  logic [DLY_W-1:0] delay;
  logic             dead_q;
  mem_req_t         req_in [2];
  mem_req_t         req_q  [2];
  logic [1:0]       rdy_q;
  logic [15:0]      rdata_q [2];
  logic [1:0]       end_hit;
  logic [1:0]       rd_hit;
  logic             sel_gsu;
  rom_word_u        dq;
  logic [15:0]      rd_word;

  assign req_in[GSU] = gsu_req;
  assign req_in[MCU] = mcu_req;

  ////////////////////////////////////////////////////////////////////////////
  // request latches
  ////////////////////////////////////////////////////////////////////////////

  assign end_hit[GSU] = (state == ST_GSU_RD_END) || (state == ST_GSU_WR_END);
  assign end_hit[MCU] = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  // ready drops on accept and comes back the cycle after the end state
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      rdy_q <= '1;
      for (int c = 0; c < 2; c++) begin
        req_q[c].rrq <= 1'b0;
        req_q[c].wrq <= 1'b0;
      end
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (req_in[c].rrq | req_in[c].wrq) begin
          req_q[c] <= req_in[c];
          rdy_q[c] <= 1'b0;
        end else if (end_hit[c]) begin
          req_q[c].rrq <= 1'b0;
          req_q[c].wrq <= 1'b0;
          rdy_q[c]     <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state  <= ST_IDLE;
      delay  <= '0;
      dead_q <= 1'b1;
    end else begin
      dead_q <= snes_dead;
      if (acc_active) begin
        delay <= delay - 1'b1;
      end
      // console came alive so drop the grant but keep what is pending
      if (dead_q & ~snes_dead) begin
        state <= ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            if (free_slot | snes_dead) begin
              delay <= CYCLE_INIT;
              if (req_q[GSU].rrq) begin
                state <= ST_GSU_RD_ADDR;
              end else if (req_q[GSU].wrq) begin
                state <= ST_GSU_WR_ADDR;
              end else if (req_q[MCU].rrq) begin
                state <= ST_MCU_RD_ADDR;
              end else if (req_q[MCU].wrq) begin
                state <= ST_MCU_WR_ADDR;
              end
            end
          end
          ST_GSU_RD_ADDR: if (delay == '0) state <= ST_GSU_RD_END;
          ST_GSU_WR_ADDR: if (delay == '0) state <= ST_GSU_WR_END;
          ST_MCU_RD_ADDR: if (delay == '0) state <= ST_MCU_RD_END;
          ST_MCU_WR_ADDR: if (delay == '0) state <= ST_MCU_WR_END;
          // all end states
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // current access toward the pins
  ////////////////////////////////////////////////////////////////////////////

  assign sel_gsu    = (state == ST_GSU_RD_ADDR) || (state == ST_GSU_WR_ADDR);
  assign acc_active = sel_gsu || (state == ST_MCU_RD_ADDR) || (state == ST_MCU_WR_ADDR);
  assign acc_write  = (state == ST_GSU_WR_ADDR) || (state == ST_MCU_WR_ADDR);
  assign acc_addr   = sel_gsu ? req_q[GSU].addr : req_q[MCU].addr;
  // mcu is byte only
  assign acc_word   = sel_gsu & req_q[GSU].word;
  assign acc_wdata  = sel_gsu ? req_q[GSU].wdata : req_q[MCU].wdata;

  ////////////////////////////////////////////////////////////////////////////
  // read data capture
  ////////////////////////////////////////////////////////////////////////////

  assign dq = rom_dq_in;

  // odd word reads come back swapped
  // byte reads move the selected lane into the low bits
  always_comb begin
    if (acc_word) begin
      rd_word = acc_addr[0] ? {dq.b.lo, dq.b.hi} : dq.word;
    end else begin
      rd_word = {8'h00, (acc_addr[0] ? dq.b.lo : dq.b.hi)};
    end
  end

  assign rd_hit[GSU] = (state == ST_GSU_RD_ADDR);
  assign rd_hit[MCU] = (state == ST_MCU_RD_ADDR);

  // resampled every address cycle so the last one wins
  always_ff @(posedge CLK2) begin
    for (int c = 0; c < 2; c++) begin
      if (rd_hit[c]) begin
        rdata_q[c] <= rd_word;
      end
    end
  end

  assign gsu_rsp.rdy   = rdy_q[GSU];
  assign gsu_rsp.rdata = rdata_q[GSU];
  assign mcu_rsp.rdy   = rdy_q[MCU];
  assign mcu_rsp.rdata = rdata_q[MCU];

  // client protocol checks
  for (genvar c = 0; c < 2; c++) begin : g_chk
    a_one_op: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
      !(req_in[c].rrq && req_in[c].wrq));
    a_req_rdy: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
      (req_in[c].rrq || req_in[c].wrq) |-> rdy_q[c]);
  end

endmodule

`default_nettype wire

/* hw/rom_bus_drive.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_bus_drive (
  input  snes_bus_pkg::snes_bus_t              bus,
  input  logic [rom_mem_pkg::ROM_ADDR_W:0]     acc_addr,
  input  logic                                 acc_word,
  input  logic                                 acc_write,
  input  logic                                 acc_active,
  input  logic [15:0]                          acc_wdata,
  output logic [rom_mem_pkg::ROM_ADDR_W-1:0]   rom_addr,
  output logic                                 rom_bhe,
  output logic                                 rom_ble,
  output logic                                 rom_we,
  output logic [15:0]                          rom_dq_out,
  output logic                                 rom_dq_oe
);

  import rom_mem_pkg::*;

  logic      addr0;
  logic      word_acc;
  rom_word_u wd;

  ////////////////////////////////////////////////////////////////////////////
  // address mux
  ////////////////////////////////////////////////////////////////////////////

  // granted client owns the bus, snes address otherwise
  assign rom_addr = acc_active ? acc_addr[ROM_ADDR_W:1] : bus.addr[ROM_ADDR_W:1];
  assign addr0    = acc_active ? acc_addr[0] : bus.addr[0];

  // word access needs both lanes
  assign word_acc = acc_active & acc_word;

  // lane enables active low
  // even byte sits on the high lane
  assign rom_bhe = addr0 & ~word_acc;
  assign rom_ble = ~addr0 & ~word_acc;

  ////////////////////////////////////////////////////////////////////////////
  // write path
  ////////////////////////////////////////////////////////////////////////////

  assign rom_we    = ~(acc_active & acc_write);
  assign rom_dq_oe = acc_active & acc_write;

  assign wd = acc_wdata;

  // same swap as the read side
  // byte goes out on both lanes, the enables pick one
  always_comb begin
    if (word_acc) begin
      rom_dq_out = addr0 ? {wd.b.lo, wd.b.hi} : wd.word;
    end else begin
      rom_dq_out = {wd.b.lo, wd.b.lo};
    end
  end

endmodule

`default_nettype wire

/* hw/snes_rom_arbiter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_rom_arbiter_top #(
  parameter int unsigned ROM_CYCLE_LEN = 6,
  parameter int unsigned DEAD_TIMEOUT  = 96000
) (
  input  logic                                 CLK2,
  input  logic                                 SNES_reset_strobe,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] SNES_ADDR_IN,
  input  logic                                 SNES_READ_IN,
  input  logic                                 SNES_WRITE_IN,
  input  logic                                 SNES_ROMSEL_IN,
  input  logic                                 SNES_CPU_CLK_IN,
  input  rom_mem_pkg::mem_req_t                gsu_req,
  input  rom_mem_pkg::mem_req_t                mcu_req,
  output rom_mem_pkg::mem_rsp_t                gsu_rsp,
  output rom_mem_pkg::mem_rsp_t                mcu_rsp,
  output logic [rom_mem_pkg::ROM_ADDR_W-1:0]   rom_addr,
  output logic                                 rom_bhe,
  output logic                                 rom_ble,
  output logic                                 rom_we,
  output logic [15:0]                          rom_dq_out,
  output logic                                 rom_dq_oe,
  input  logic [15:0]                          rom_dq_in
);

  import snes_bus_pkg::*;
  import rom_mem_pkg::*;

  snes_bus_t           bus;
  logic                free_slot;
  logic                snes_dead;
  logic [ROM_ADDR_W:0] acc_addr;
  logic                acc_word;
  logic                acc_write;
  logic                acc_active;
  logic [15:0]         acc_wdata;

  // snes input side
  snes_bus_sync #(
    .DEAD_TIMEOUT(DEAD_TIMEOUT)
  ) sync0 (
    .CLK2(CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .addr_in(SNES_ADDR_IN),
    .read_in(SNES_READ_IN),
    .write_in(SNES_WRITE_IN),
    .romsel_in(SNES_ROMSEL_IN),
    .cpu_clk_in(SNES_CPU_CLK_IN),
    .bus(bus),
    .free_slot(free_slot),
    .snes_dead(snes_dead)
  );

  // slot sharing between coprocessor and mcu
  rom_arbiter #(
    .ROM_CYCLE_LEN(ROM_CYCLE_LEN)
  ) arb0 (
    .CLK2(CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .free_slot(free_slot),
    .snes_dead(snes_dead),
    .gsu_req(gsu_req),
    .mcu_req(mcu_req),
    .rom_dq_in(rom_dq_in),
    .gsu_rsp(gsu_rsp),
    .mcu_rsp(mcu_rsp),
    .acc_addr(acc_addr),
    .acc_word(acc_word),
    .acc_write(acc_write),
    .acc_active(acc_active),
    .acc_wdata(acc_wdata)
  );

  // psram pins
  rom_bus_drive drv0 (
    .bus(bus),
    .acc_addr(acc_addr),
    .acc_word(acc_word),
    .acc_write(acc_write),
    .acc_active(acc_active),
    .acc_wdata(acc_wdata),
    .rom_addr(rom_addr),
    .rom_bhe(rom_bhe),
    .rom_ble(rom_ble),
    .rom_we(rom_we),
    .rom_dq_out(rom_dq_out),
    .rom_dq_oe(rom_dq_oe)
  );

endmodule

`default_nettype wire

/* verif/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

  ////////////////////////////////////////////////////////////////////////////
  // reporting and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // power-up word where every address bit takes part
  function automatic logic [15:0] fill_word(input logic [MEM_AW-1:0] a);
    return {a[11:4], a[7:0]} ^ 16'hc35a;
  endfunction

  // even byte address inside the model
  function automatic logic [BA_W-1:0] rand_even_addr();
    return BA_W'($urandom) & BA_W'(2 * (2**MEM_AW) - 2);
  endfunction

  // one cycle at a time until the client is ready again
  task automatic wait_ready(input logic to_gsu, input int limit);
    int n;
    n = 0;
    while (!(to_gsu ? gsu_rsp.rdy : mcu_rsp.rdy)) begin
      if (n >= limit) begin
        stop_run($sformatf("%s ready did not return within %0d cycles",
                           to_gsu ? "gsu" : "mcu", limit));
      end
      @(posedge CLK2);
      #1;
      n++;
    end
  endtask

  // request fields go up and the pulse starts now
  task automatic set_req(input logic to_gsu, input logic wr, input logic word,
                         input logic [BA_W-1:0] addr, input logic [15:0] wdata);
    mem_req_t r;
    r.rrq   = ~wr;
    r.wrq   = wr;
    r.word  = word;
    r.addr  = addr;
    r.wdata = wdata;
    if (to_gsu) begin
      gsu_req = r;
    end else begin
      mcu_req = r;
    end
  endtask

  // pulse is one cycle wide
  task automatic end_pulse();
    @(posedge CLK2);
    #1;
    gsu_req.rrq = 1'b0;
    gsu_req.wrq = 1'b0;
    mcu_req.rrq = 1'b0;
    mcu_req.wrq = 1'b0;
  endtask

  // full handshake with read data returned when ready is back
  task automatic run_access(input logic to_gsu, input logic wr, input logic word,
                            input logic [BA_W-1:0] addr, input logic [15:0] wdata,
                            input int limit, output logic [15:0] rdata);
    wait_ready(to_gsu, limit);
    set_req(to_gsu, wr, word, addr, wdata);
    end_pulse();
    wait_ready(to_gsu, limit);
    rdata = to_gsu ? gsu_rsp.rdata : mcu_rsp.rdata;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    check_value("check_reset_state gsu ready", 32'(1), 32'(gsu_rsp.rdy));
    check_value("check_reset_state mcu ready", 32'(1), 32'(mcu_rsp.rdy));
    check_value("check_reset_state rom_we", 32'(1), 32'(rom_we));
    check_value("check_reset_state rom_dq_oe", 32'(0), 32'(rom_dq_oe));
  endtask

  // with the console dead a byte lands on the lane of its address and comes back low
  task automatic mcu_byte_roundtrip();
    logic [BA_W-1:0] a;
    logic [7:0]      b;
    logic [15:0]     rd;
    for (int k = 0; k < 2; k++) begin
      a = rand_even_addr() | BA_W'(k);
      b = 8'($urandom);
      // junk in the high half must not matter
      run_access(1'b0, 1'b1, 1'b0, a, {8'($urandom), b}, WAIT_LIMIT, rd);
      run_access(1'b0, 1'b0, 1'b0, a, 16'h0000, WAIT_LIMIT, rd);
      check_value($sformatf("mcu_byte_roundtrip at %0h", a), 32'({8'h00, b}), 32'(rd));
    end
  endtask

  // even address reads straight and odd address reads byte swapped in both directions
  task automatic gsu_word_swap();
    logic [BA_W-1:0] a;
    logic [15:0]     w;
    logic [15:0]     rd;
    a = rand_even_addr();
    w = 16'($urandom);
    run_access(1'b1, 1'b1, 1'b1, a, w, WAIT_LIMIT, rd);
    run_access(1'b1, 1'b0, 1'b1, a, 16'h0000, WAIT_LIMIT, rd);
    check_value("gsu_word_swap even read", 32'(w), 32'(rd));
    run_access(1'b1, 1'b0, 1'b1, a | BA_W'(1), 16'h0000, WAIT_LIMIT, rd);
    check_value("gsu_word_swap odd read", 32'({w[7:0], w[15:8]}), 32'(rd));
    // written through the odd address and read back at the even one
    a = rand_even_addr() | BA_W'(1);
    w = 16'($urandom);
    run_access(1'b1, 1'b1, 1'b1, a, w, WAIT_LIMIT, rd);
    run_access(1'b1, 1'b0, 1'b1, a, 16'h0000, WAIT_LIMIT, rd);
    check_value("gsu_word_swap odd write odd read", 32'(w), 32'(rd));
    run_access(1'b1, 1'b0, 1'b1, a & ~BA_W'(1), 16'h0000, WAIT_LIMIT, rd);
    check_value("gsu_word_swap odd write even read", 32'({w[7:0], w[15:8]}), 32'(rd));
  endtask

  // odd byte is the low half of the word at the even address below
  task automatic mcu_byte_in_gsu_word();
    logic [BA_W-1:0] a;
    logic [15:0]     w;
    logic [7:0]      b;
    logic [15:0]     rd;
    a = rand_even_addr();
    w = 16'($urandom);
    b = 8'($urandom);
    run_access(1'b1, 1'b1, 1'b1, a, w, WAIT_LIMIT, rd);
    run_access(1'b0, 1'b1, 1'b0, a | BA_W'(1), {8'h00, b}, WAIT_LIMIT, rd);
    run_access(1'b1, 1'b0, 1'b1, a, 16'h0000, WAIT_LIMIT, rd);
    check_value("mcu_byte_in_gsu_word", 32'({w[15:8], b}), 32'(rd));
  endtask

  // with same-cycle requests the coprocessor is served first
  task automatic gsu_priority();
    logic [BA_W-1:0] ga;
    logic [BA_W-1:0] ma;
    logic [15:0]     w;
    logic [7:0]      b;
    logic [15:0]     rd;
    int              n;
    int              gsu_at;
    int              mcu_at;
    ga = rand_even_addr();
    // mcu byte sits in the neighbouring word so the two writes never overlap
    ma = (ga ^ BA_W'(2)) | BA_W'(1);
    w  = 16'($urandom);
    b  = 8'($urandom);
    run_access(1'b1, 1'b1, 1'b1, ga, w, WAIT_LIMIT, rd);
    run_access(1'b0, 1'b1, 1'b0, ma, {8'h00, b}, WAIT_LIMIT, rd);
    set_req(1'b1, 1'b0, 1'b1, ga, 16'h0000);
    set_req(1'b0, 1'b0, 1'b0, ma, 16'h0000);
    end_pulse();
    n      = 0;
    gsu_at = -1;
    mcu_at = -1;
    while (!(gsu_rsp.rdy && mcu_rsp.rdy)) begin
      if (n >= WAIT_LIMIT) begin
        stop_run("gsu_priority: readies did not both return in time");
      end
      @(posedge CLK2);
      #1;
      n++;
      if (gsu_rsp.rdy && gsu_at < 0) begin
        gsu_at = n;
      end
      if (mcu_rsp.rdy && mcu_at < 0) begin
        mcu_at = n;
      end
    end
    check_value("gsu_priority gsu ready first", 32'(1), 32'(gsu_at < mcu_at));
    check_value("gsu_priority gsu data", 32'(w), 32'(gsu_rsp.rdata));
    check_value("gsu_priority mcu data", 32'({8'h00, b}), 32'(mcu_rsp.rdata));
  endtask

  // live console with rom hits where requests only go in free slots
  task automatic live_snes_access();
    logic [SNES_ADDR_W-1:0] sa;
    logic [BA_W-1:0]        a;
    logic [7:0]             b;
    logic [15:0]            rd;
    snes_romsel = 1'b0;
    snes_run    = 1'b1;
    // a few snes cycles so the dead flag clears
    repeat (4 * SNES_PERIOD) begin
      @(posedge CLK2);
    end
    #1;
    for (int k = 0; k < 4; k++) begin
      sa        = SNES_ADDR_W'($urandom);
      snes_addr = sa;
      // longer than the input filter lag
      repeat (8) begin
        @(posedge CLK2);
      end
      #1;
      check_value("live_snes_access idle rom_addr", 32'(sa[SNES_ADDR_W-1:1]), 32'(rom_addr));
      check_value("live_snes_access idle rom_we", 32'(1), 32'(rom_we));
    end
    // bounded by a few snes cycles
    a = rand_even_addr() | BA_W'(1);
    b = 8'($urandom);
    run_access(1'b0, 1'b1, 1'b0, a, {8'h00, b}, 4 * SNES_PERIOD, rd);
    run_access(1'b0, 1'b0, 1'b0, a, 16'h0000, 4 * SNES_PERIOD, rd);
    check_value("live_snes_access mcu byte", 32'({8'h00, b}), 32'(rd));
  endtask

`endif

/* verif/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import snes_bus_pkg::*;
  import rom_mem_pkg::*;

  // byte address width on the client side
  localparam int          BA_W        = ROM_ADDR_W + 1;
  // model covers 4k words and tests stay inside
  localparam int          MEM_AW      = 12;
  // snes cpu clock period in CLK2 cycles
  localparam int          SNES_PERIOD = 12;
  localparam int          WAIT_LIMIT  = 200;
  localparam int unsigned SEED        = 32'h71be_b23e;

  logic                   CLK2 = 1'b0;
  logic                   SNES_reset_strobe;
  logic [SNES_ADDR_W-1:0] snes_addr;
  logic                   snes_read;
  logic                   snes_write;
  logic                   snes_romsel;
  logic                   snes_cpu_clk;
  logic                   snes_run;
  int                     snes_phase;
  mem_req_t               gsu_req;
  mem_req_t               mcu_req;
  mem_rsp_t               gsu_rsp;
  mem_rsp_t               mcu_rsp;
  logic [ROM_ADDR_W-1:0]  rom_addr;
  logic                   rom_bhe;
  logic                   rom_ble;
  logic                   rom_we;
  logic [15:0]            rom_dq_out;
  logic                   rom_dq_oe;
  logic [15:0]            rom_dq_in;
  logic [15:0]            psram [2**MEM_AW];

  `include "tb_tests.svh"

  // 8 ns period
  always #4 CLK2 = ~CLK2;

  snes_rom_arbiter_top #(
    .ROM_CYCLE_LEN(6),
    .DEAD_TIMEOUT(64)
  ) dut0 (
    .CLK2(CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .SNES_ADDR_IN(snes_addr),
    .SNES_READ_IN(snes_read),
    .SNES_WRITE_IN(snes_write),
    .SNES_ROMSEL_IN(snes_romsel),
    .SNES_CPU_CLK_IN(snes_cpu_clk),
    .gsu_req(gsu_req),
    .mcu_req(mcu_req),
    .gsu_rsp(gsu_rsp),
    .mcu_rsp(mcu_rsp),
    .rom_addr(rom_addr),
    .rom_bhe(rom_bhe),
    .rom_ble(rom_ble),
    .rom_we(rom_we),
    .rom_dq_out(rom_dq_out),
    .rom_dq_oe(rom_dq_oe),
    .rom_dq_in(rom_dq_in)
  );

  ////////////////////////////////////////////////////////////////////////////
  // psram model
  ////////////////////////////////////////////////////////////////////////////

  // contents reload while reset is held
  // lane enables are active low with the even byte on the high lane
  always @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      for (int i = 0; i < 2**MEM_AW; i++) begin
        psram[i] <= fill_word(MEM_AW'(i));
      end
    end else if (!rom_we) begin
      if (!rom_dq_oe) begin
        stop_run("psram write strobe seen while the data bus is not driven");
      end
      if (!rom_bhe) begin
        psram[rom_addr[MEM_AW-1:0]][15:8] <= rom_dq_out[15:8];
      end
      if (!rom_ble) begin
        psram[rom_addr[MEM_AW-1:0]][7:0] <= rom_dq_out[7:0];
      end
    end
  end

  // asynchronous read of the addressed word
  assign rom_dq_in = psram[rom_addr[MEM_AW-1:0]];

  ////////////////////////////////////////////////////////////////////////////
  // snes cpu clock and test sequence
  ////////////////////////////////////////////////////////////////////////////

  // half high and half low while running and held low otherwise
  initial begin
    snes_cpu_clk = 1'b0;
    snes_phase   = 0;
    forever begin
      @(posedge CLK2);
      #1;
      if (snes_run) begin
        snes_phase   = (snes_phase + 1) % SNES_PERIOD;
        snes_cpu_clk = (snes_phase < SNES_PERIOD / 2);
      end else begin
        snes_phase   = 0;
        snes_cpu_clk = 1'b0;
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    SNES_reset_strobe = 1'b1;
    snes_addr         = '0;
    snes_read         = 1'b1;
    snes_write        = 1'b1;
    snes_romsel       = 1'b1;
    snes_run          = 1'b0;
    gsu_req           = '0;
    mcu_req           = '0;
    repeat (16) begin
      @(posedge CLK2);
    end
    #1;
    SNES_reset_strobe = 1'b0;

    // console stays dead until the last test
    check_reset_state();
    mcu_byte_roundtrip();
    gsu_word_swap();
    mcu_byte_in_gsu_word();
    gsu_priority();
    live_snes_access();

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* snes_rom_arbiter.f */
+incdir+verif
hw/snes_bus_pkg.sv
hw/rom_mem_pkg.sv
hw/snes_bus_sync.sv
hw/rom_arbiter.sv
hw/rom_bus_drive.sv
hw/snes_rom_arbiter_top.sv
verif/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_top -f snes_rom_arbiter.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
